//--- verilog/cad_pkg.sv
package cad_pkg;

  // ------------------------------------------------------------
  // Sizes and widths
  // ------------------------------------------------------------
  localparam int DATA_W   = 8;
  localparam int ACC_W    = 20;
  localparam int KSIZE    = 5;
  localparam int MAX_SIZE = 16;
  localparam int IDX_W    = 4;
  localparam int COORD_W  = 5;

  // Pixel and weight, both two's complement
  typedef logic signed [DATA_W-1:0] pixel_t;

  // Wide enough for 25 full-scale products
  typedef logic signed [ACC_W-1:0] acc_t;

  // Engine phase shared by job registers, loader and scheduler
  typedef enum logic [1:0] {
    ph_idle,
    ph_load,
    ph_wait_idx,
    ph_run
  } phase_t;

endpackage

//--- verilog/cad_job_regs.sv
`timescale 1ns/100ps

module cad_job_regs #(
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2,
  localparam int IMG_SEL_W = $clog2(IMG_COUNT),
  localparam int KER_SEL_W = $clog2(KER_COUNT)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  logic                      in_valid2,
  input  logic [cad_pkg::IDX_W-1:0] matrix_idx,
  input  logic [1:0]                matrix_size,
  input  logic                      load_done,
  input  logic                      job_done,
  output cad_pkg::phase_t           phase,
  output logic                      img_size_8,
  output logic [IMG_SEL_W-1:0]      img_sel,
  output logic [KER_SEL_W-1:0]      ker_sel
);
  import cad_pkg::*;

  logic start_load;
  logic idx_second;

  // First byte of a burst, from idle or as a reload
  assign start_load = in_valid && (phase == ph_idle || phase == ph_wait_idx);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase      <= ph_idle;
      img_size_8 <= 1'b0;
      img_sel    <= '0;
      ker_sel    <= '0;
      idx_second <= 1'b0;
    end
    else if (start_load)
    begin
      phase      <= ph_load;
      // Size 0 is 8x8, anything else runs as 16x16
      img_size_8 <= (matrix_size == 2'd0);
      idx_second <= 1'b0;
    end
    else
    begin
      case (phase)
        ph_load:
        begin
          if (load_done)
            phase <= ph_wait_idx;
        end
        ph_wait_idx:
        begin
          if (in_valid2 && idx_second)
          begin
            ker_sel    <= matrix_idx[KER_SEL_W-1:0];
            idx_second <= 1'b0;
            phase      <= ph_run;
          end
          else if (in_valid2)
          begin
            img_sel    <= matrix_idx[IMG_SEL_W-1:0];
            idx_second <= 1'b1;
          end
        end
        ph_run:
        begin
          if (job_done)
            phase <= ph_wait_idx;
        end
        default:
          phase <= ph_idle;
      endcase
    end
  end

  // Index pairs only arrive between jobs
  a_idx_only_waiting: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid2 |-> !(phase inside {ph_load, ph_run}))
    else $error("in_valid2 during load or run phase");

endmodule

//--- verilog/cad_load_ctrl.sv
`timescale 1ns/100ps

module cad_load_ctrl #(
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2,
  localparam int IMG_AW = $clog2(IMG_COUNT * cad_pkg::MAX_SIZE * cad_pkg::MAX_SIZE),
  localparam int KER_AW = $clog2(KER_COUNT * cad_pkg::KSIZE * cad_pkg::KSIZE)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  cad_pkg::phase_t   phase,
  input  logic              img_size_8,
  output logic              load_done,
  output logic              img_we,
  output logic [IMG_AW-1:0] img_waddr,
  output logic              ker_we,
  output logic [KER_AW-1:0] ker_waddr
);
  import cad_pkg::*;

  localparam int IMG_NUM_W = $clog2(IMG_COUNT);
  localparam int KER_BYTES = KER_COUNT * KSIZE * KSIZE;

  logic [COORD_W-1:0]   col;
  logic [COORD_W-1:0]   row;
  logic [COORD_W-1:0]   edge_idx;
  logic [IMG_NUM_W-1:0] img_num;
  logic [KER_AW-1:0]    ker_cnt;
  logic                 in_ker;
  logic                 active;

  // Counting starts in the idle cycle that carries the first byte
  assign active   = in_valid && (phase != ph_run);
  assign edge_idx = img_size_8 ? COORD_W'(MAX_SIZE / 2 - 1) : COORD_W'(MAX_SIZE - 1);

  assign img_we    = active && !in_ker;
  assign ker_we    = active && in_ker;
  // Fixed row stride, so 8x8 images sit in the top-left corner
  assign img_waddr = IMG_AW'(img_num * MAX_SIZE * MAX_SIZE + row * MAX_SIZE + col);
  assign ker_waddr = ker_cnt;
  assign load_done = ker_we && (ker_cnt == KER_AW'(KER_BYTES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      col     <= '0;
      row     <= '0;
      img_num <= '0;
      ker_cnt <= '0;
      in_ker  <= 1'b0;
    end
    else if (load_done)
    begin
      // Back to the first image for the next burst
      col     <= '0;
      row     <= '0;
      img_num <= '0;
      ker_cnt <= '0;
      in_ker  <= 1'b0;
    end
    else if (ker_we)
      ker_cnt <= ker_cnt + 1'b1;
    else if (img_we)
    begin
      if (col == edge_idx)
      begin
        col <= '0;
        if (row == edge_idx)
        begin
          row <= '0;
          if (img_num == IMG_NUM_W'(IMG_COUNT - 1))
            in_ker <= 1'b1;
          else
            img_num <= img_num + 1'b1;
        end
        else
          row <= row + 1'b1;
      end
      else
        col <= col + 1'b1;
    end
  end

endmodule

//--- verilog/cad_feature_mem.sv
`timescale 1ns/100ps

module cad_feature_mem #(
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2,
  localparam int IMG_DEPTH = IMG_COUNT * cad_pkg::MAX_SIZE * cad_pkg::MAX_SIZE,
  localparam int KER_DEPTH = KER_COUNT * cad_pkg::KSIZE * cad_pkg::KSIZE,
  localparam int IMG_AW    = $clog2(IMG_DEPTH),
  localparam int KER_AW    = $clog2(KER_DEPTH),
  localparam int KROW_W    = $clog2(KER_COUNT * cad_pkg::KSIZE)
) (
  input  logic              clk,
  input  cad_pkg::pixel_t   matrix,
  input  logic              img_we,
  input  logic [IMG_AW-1:0] img_waddr,
  input  logic              ker_we,
  input  logic [KER_AW-1:0] ker_waddr,
  input  logic [IMG_AW-1:0] img_raddr [cad_pkg::KSIZE],
  input  logic [KROW_W-1:0] ker_rrow,
  output cad_pkg::pixel_t   img_rdata [cad_pkg::KSIZE],
  output cad_pkg::pixel_t   ker_rdata [cad_pkg::KSIZE]
);
  import cad_pkg::*;

  pixel_t img_mem [IMG_DEPTH];
  pixel_t ker_mem [KER_DEPTH];

  // Write ports, data straight from the input bus
  always_ff @(posedge clk)
  begin
    if (img_we)
      img_mem[img_waddr] <= matrix;
    if (ker_we)
      ker_mem[ker_waddr] <= matrix;
  end

  // Five neighbouring pixels and one kernel row per cycle
  always_ff @(posedge clk)
  begin
    for (int k = 0; k < KSIZE; k++)
    begin
      img_rdata[k] <= img_mem[img_raddr[k]];
      ker_rdata[k] <= ker_mem[KER_AW'(ker_rrow * KSIZE + k)];
    end
  end

endmodule

//--- verilog/cad_conv_sched.sv
`timescale 1ns/100ps

module cad_conv_sched #(
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2,
  localparam int IMG_AW    = $clog2(IMG_COUNT * cad_pkg::MAX_SIZE * cad_pkg::MAX_SIZE),
  localparam int KROW_W    = $clog2(KER_COUNT * cad_pkg::KSIZE),
  localparam int IMG_SEL_W = $clog2(IMG_COUNT),
  localparam int KER_SEL_W = $clog2(KER_COUNT)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cad_pkg::phase_t      phase,
  input  logic                 img_size_8,
  input  logic [IMG_SEL_W-1:0] img_sel,
  input  logic [KER_SEL_W-1:0] ker_sel,
  output logic [IMG_AW-1:0]    img_raddr [cad_pkg::KSIZE],
  output logic [KROW_W-1:0]    ker_rrow,
  output logic                 row_valid,
  output logic                 row_last,
  output logic                 win_last,
  output logic                 job_done
);
  import cad_pkg::*;

  logic [2:0]         krow;
  logic [1:0]         pos;
  logic [COORD_W-1:0] wx;
  logic [COORD_W-1:0] wy;
  logic [COORD_W-1:0] last_w;
  logic [COORD_W-1:0] conv_x;
  logic [COORD_W-1:0] pix_y;
  logic               issue;
  logic               kernel_end;
  logic               window_end;
  logic               image_end;

  // ------------------------------------------------------------
  // Position counters
  // ------------------------------------------------------------
  // Issue stops in the job_done cycle and phase leaves run one cycle later
  assign issue      = (phase == ph_run) && !job_done;
  assign kernel_end = (krow == 3'(KSIZE - 1));
  assign window_end = kernel_end && (pos == 2'd3);
  // Last pooling window index is 1 for 8x8 and 5 for 16x16
  assign last_w     = img_size_8 ? COORD_W'((MAX_SIZE / 2 - 4) / 2 - 1)
                                 : COORD_W'((MAX_SIZE - 4) / 2 - 1);
  assign image_end  = window_end && (wx == last_w) && (wy == last_w);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      krow <= '0;
      pos  <= '0;
      wx   <= '0;
      wy   <= '0;
    end
    else if (issue)
    begin
      krow <= kernel_end ? 3'd0 : krow + 1'b1;
      if (kernel_end)
        pos <= pos + 1'b1;
      if (window_end)
      begin
        wx <= (wx == last_w) ? '0 : wx + 1'b1;
        if (wx == last_w)
          wy <= (wy == last_w) ? '0 : wy + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Read addresses
  // ------------------------------------------------------------
  // pos bit 0 steps right and bit 1 steps down inside the 2x2 window
  assign conv_x   = COORD_W'(2 * wx + pos[0]);
  assign pix_y    = COORD_W'(2 * wy + pos[1] + krow);
  assign ker_rrow = KROW_W'(ker_sel * KSIZE + krow);

  always_comb
  begin
    for (int k = 0; k < KSIZE; k++)
      img_raddr[k] = IMG_AW'(img_sel * MAX_SIZE * MAX_SIZE + pix_y * MAX_SIZE + conv_x + k);
  end

  // Tags lag one cycle to line up with the read data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_valid <= 1'b0;
      row_last  <= 1'b0;
      win_last  <= 1'b0;
      job_done  <= 1'b0;
    end
    else
    begin
      row_valid <= issue;
      row_last  <= issue && kernel_end;
      win_last  <= issue && window_end;
      job_done  <= issue && image_end;
    end
  end

  // A last-row tag closes five valid kernel rows in a row
  a_last_is_valid: assert property (@(posedge clk) disable iff (!rst_n)
    row_last |-> row_valid && $past(row_valid, 1) && $past(row_valid, 2)
                 && $past(row_valid, 3) && $past(row_valid, 4))
    else $error("row_last tag without five valid kernel rows before it");

endmodule

//--- verilog/cad_mac_pool.sv
`timescale 1ns/100ps

module cad_mac_pool (
  input  logic            clk,
  input  logic            rst_n,
  input  cad_pkg::pixel_t img_rdata [cad_pkg::KSIZE],
  input  cad_pkg::pixel_t ker_rdata [cad_pkg::KSIZE],
  input  logic            row_valid,
  input  logic            row_last,
  input  logic            win_last,
  output logic            res_valid,
  output cad_pkg::acc_t   res_data
);
  import cad_pkg::*;

  acc_t row_prod;
  acc_t row_sum;
  acc_t acc;
  acc_t conv_val;
  acc_t run_max;
  acc_t win_max;
  logic sum_valid;
  logic sum_last;
  logic sum_win;
  logic win_first;

  // Five-way multiply-add of one kernel row
  always_comb
  begin
    row_prod = '0;
    for (int k = 0; k < KSIZE; k++)
      row_prod = row_prod + acc_t'(img_rdata[k]) * acc_t'(ker_rdata[k]);
  end

  assign conv_val = acc + row_sum;
  // Signed compare, first conv value of a window always wins
  assign win_max  = (win_first || conv_val > run_max) ? conv_val : run_max;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sum_valid <= 1'b0;
      sum_last  <= 1'b0;
      sum_win   <= 1'b0;
      res_valid <= 1'b0;
      win_first <= 1'b1;
      acc       <= '0;
    end
    else
    begin
      sum_valid <= row_valid;
      sum_last  <= row_valid && row_last;
      sum_win   <= row_valid && win_last;
      res_valid <= sum_valid && sum_win;
      if (sum_valid)
      begin
        acc <= sum_last ? '0 : conv_val;
        if (sum_last)
          win_first <= sum_win;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    row_sum <= row_prod;
    if (sum_valid && sum_last)
      run_max <= win_max;
    if (sum_valid && sum_win)
      res_data <= win_max;
  end

endmodule

//--- verilog/cad_serializer.sv
`timescale 1ns/100ps

module cad_serializer (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          res_valid,
  input  cad_pkg::acc_t res_data,
  output logic          out_valid,
  output logic          out_value
);
  import cad_pkg::*;

  localparam int CNT_W = $clog2(ACC_W);

  acc_t             pend_data;
  acc_t             shift_q;
  logic             pend_valid;
  logic             load;
  logic [CNT_W-1:0] bit_cnt;

  // Next word goes out right behind the last bit of the current one
  assign load = pend_valid && (!out_valid || bit_cnt == CNT_W'(ACC_W - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_valid <= 1'b0;
      out_valid  <= 1'b0;
      out_value  <= 1'b0;
      bit_cnt    <= '0;
    end
    else
    begin
      if (res_valid)
        pend_valid <= 1'b1;
      else if (load)
        pend_valid <= 1'b0;

      if (load)
      begin
        out_valid <= 1'b1;
        out_value <= pend_data[0];
        bit_cnt   <= '0;
      end
      else if (out_valid && bit_cnt != CNT_W'(ACC_W - 1))
      begin
        out_value <= shift_q[0];
        bit_cnt   <= bit_cnt + 1'b1;
      end
      else
      begin
        out_valid <= 1'b0;
        out_value <= 1'b0;
      end
    end
  end

  // LSB first
  always_ff @(posedge clk)
  begin
    if (res_valid)
      pend_data <= res_data;
    shift_q <= load ? pend_data >> 1 : shift_q >> 1;
  end

  // MAC spacing of 20 cycles keeps the single pending slot free
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> !pend_valid)
    else $error("result arrived while a word was still pending");

endmodule

//--- verilog/cad_top.sv
`timescale 1ns/100ps

module cad_top #(
  parameter int IMG_COUNT = 2,
  parameter int KER_COUNT = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  logic                          in_valid2,
  input  cad_pkg::pixel_t               matrix,
  input  logic [cad_pkg::IDX_W-1:0]     matrix_idx,
  input  logic [1:0]                    matrix_size,
  output logic                          out_valid,
  output logic                          out_value
);
  import cad_pkg::*;

  localparam int IMG_AW    = $clog2(IMG_COUNT * MAX_SIZE * MAX_SIZE);
  localparam int KER_AW    = $clog2(KER_COUNT * KSIZE * KSIZE);
  localparam int KROW_W    = $clog2(KER_COUNT * KSIZE);
  localparam int IMG_SEL_W = $clog2(IMG_COUNT);
  localparam int KER_SEL_W = $clog2(KER_COUNT);

  phase_t                 phase;
  logic                   img_size_8;
  logic [IMG_SEL_W-1:0]   img_sel;
  logic [KER_SEL_W-1:0]   ker_sel;
  logic                   load_done;
  logic                   job_done;

  logic                   img_we;
  logic [IMG_AW-1:0]      img_waddr;
  logic                   ker_we;
  logic [KER_AW-1:0]      ker_waddr;

  logic [IMG_AW-1:0]      img_raddr [KSIZE];
  logic [KROW_W-1:0]      ker_rrow;
  pixel_t                 img_rdata [KSIZE];
  pixel_t                 ker_rdata [KSIZE];

  logic                   row_valid;
  logic                   row_last;
  logic                   win_last;
  logic                   res_valid;
  acc_t                   res_data;

  cad_job_regs #(
    .IMG_COUNT (IMG_COUNT),
    .KER_COUNT (KER_COUNT)
  ) u_job_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_valid2   (in_valid2),
    .matrix_idx  (matrix_idx),
    .matrix_size (matrix_size),
    .load_done   (load_done),
    .job_done    (job_done),
    .phase       (phase),
    .img_size_8  (img_size_8),
    .img_sel     (img_sel),
    .ker_sel     (ker_sel)
  );

  cad_load_ctrl #(
    .IMG_COUNT (IMG_COUNT),
    .KER_COUNT (KER_COUNT)
  ) u_load_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .phase      (phase),
    .img_size_8 (img_size_8),
    .load_done  (load_done),
    .img_we     (img_we),
    .img_waddr  (img_waddr),
    .ker_we     (ker_we),
    .ker_waddr  (ker_waddr)
  );

  cad_feature_mem #(
    .IMG_COUNT (IMG_COUNT),
    .KER_COUNT (KER_COUNT)
  ) u_feature_mem (
    .clk       (clk),
    .matrix    (matrix),
    .img_we    (img_we),
    .img_waddr (img_waddr),
    .ker_we    (ker_we),
    .ker_waddr (ker_waddr),
    .img_raddr (img_raddr),
    .ker_rrow  (ker_rrow),
    .img_rdata (img_rdata),
    .ker_rdata (ker_rdata)
  );

  cad_conv_sched #(
    .IMG_COUNT (IMG_COUNT),
    .KER_COUNT (KER_COUNT)
  ) u_conv_sched (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase),
    .img_size_8 (img_size_8),
    .img_sel    (img_sel),
    .ker_sel    (ker_sel),
    .img_raddr  (img_raddr),
    .ker_rrow   (ker_rrow),
    .row_valid  (row_valid),
    .row_last   (row_last),
    .win_last   (win_last),
    .job_done   (job_done)
  );

  cad_mac_pool u_mac_pool (
    .clk       (clk),
    .rst_n     (rst_n),
    .img_rdata (img_rdata),
    .ker_rdata (ker_rdata),
    .row_valid (row_valid),
    .row_last  (row_last),
    .win_last  (win_last),
    .res_valid (res_valid),
    .res_data  (res_data)
  );

  cad_serializer u_serializer (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res_data  (res_data),
    .out_valid (out_valid),
    .out_value (out_value)
  );

endmodule

//--- verification/cad_tb_model.svh
`ifndef CAD_TB_MODEL_SVH
`define CAD_TB_MODEL_SVH

// ------------------------------------------------------------
// Expected results from the stored images and kernels
// ------------------------------------------------------------

// Valid 5x5 convolution at conv position (y, x), kernel not flipped
function automatic int conv_at(input int img, input int ker, input int y, input int x);
  int sum;
  sum = 0;
  for (int i = 0; i < KSIZE; i++)
  begin
    for (int j = 0; j < KSIZE; j++)
      sum += int'(img_store[img][y + i][x + j]) * int'(ker_store[ker][i][j]);
  end
  return sum;
endfunction

// Signed max over the 2x2 conv values starting at (y, x)
function automatic int pool_at(input int img, input int ker, input int y, input int x);
  int best;
  int val;
  best = conv_at(img, ker, y, x);
  for (int dy = 0; dy < 2; dy++)
  begin
    for (int dx = 0; dx < 2; dx++)
    begin
      val = conv_at(img, ker, y + dy, x + dx);
      if (val > best)
        best = val;
    end
  end
  return best;
endfunction

// Pooled words in raster order for an n x n image
function automatic void build_expected(input int img, input int ker, input int n);
  int w;
  w = (n - KSIZE + 1) / 2;
  exp_q.delete();
  for (int py = 0; py < w; py++)
  begin
    for (int px = 0; px < w; px++)
      exp_q.push_back(pool_at(img, ker, 2 * py, 2 * px));
  end
endfunction

`endif

//--- verification/cad_tb.sv
`timescale 1ns/100ps

module cad_tb;
  import cad_pkg::*;

  localparam int IMG_COUNT  = 2;
  localparam int KER_COUNT  = 2;
  localparam int TIMEOUT    = 2000;
  // Quiet window after the last expected bit
  localparam int QUIET      = 40;
  // out_valid cycles per job
  localparam int BITS_8X8   = 80;
  localparam int BITS_16X16 = 720;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic             in_valid2;
  pixel_t           matrix;
  logic [IDX_W-1:0] matrix_idx;
  logic [1:0]       matrix_size;
  logic             out_valid;
  logic             out_value;

  integer seed;
  int     cur_n;
  pixel_t img_store [IMG_COUNT][MAX_SIZE][MAX_SIZE];
  pixel_t ker_store [KER_COUNT][KSIZE][KSIZE];
  int     exp_q [$];
  int     got_q [$];

  `include "cad_tb_model.svh"

  cad_top #(
    .IMG_COUNT (IMG_COUNT),
    .KER_COUNT (KER_COUNT)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_valid2   (in_valid2),
    .matrix      (matrix),
    .matrix_idx  (matrix_idx),
    .matrix_size (matrix_size),
    .out_valid   (out_valid),
    .out_value   (out_value)
  );

  always #4 clk = ~clk;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // Inputs are driven and outputs sampled 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic signed [31:0] expected,
                       input logic signed [31:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  // One burst of images then kernels
  // neg_mode gives negative pixels and positive weights
  task automatic load_all(input int size_code, input bit neg_mode);
    int n;
    int v;
    n = (size_code == 0) ? MAX_SIZE / 2 : MAX_SIZE;
    cur_n = n;
    for (int i = 0; i < IMG_COUNT; i++)
      for (int r = 0; r < n; r++)
        for (int c = 0; c < n; c++)
        begin
          v = $random(seed);
          step();
          in_valid    = 1'b1;
          matrix_size = 2'(size_code);
          matrix      = neg_mode ? pixel_t'(-1 - (v & 127)) : pixel_t'(v);
          img_store[i][r][c] = matrix;
        end
    for (int k = 0; k < KER_COUNT; k++)
      for (int r = 0; r < KSIZE; r++)
        for (int c = 0; c < KSIZE; c++)
        begin
          v = $random(seed);
          step();
          matrix = neg_mode ? pixel_t'(1 + (v & 63)) : pixel_t'(v);
          ker_store[k][r][c] = matrix;
        end
    step();
    in_valid    = 1'b0;
    matrix      = '0;
    matrix_size = '0;
  endtask

  // Send the index pair, then gather LSB-first words and compare them with the model
  task automatic run_job(input string name, input int img, input int ker,
                         input int exp_cycles);
    int               total;
    int               bit_cnt;
    int               wait_cnt;
    int               extra;
    logic [ACC_W-1:0] word;
    acc_t             got;
    build_expected(img, ker, cur_n);
    got_q.delete();
    total = ACC_W * exp_q.size();
    step();
    in_valid2  = 1'b1;
    matrix_idx = IDX_W'(img);
    step();
    matrix_idx = IDX_W'(ker);
    step();
    in_valid2  = 1'b0;
    matrix_idx = '0;
    bit_cnt    = 0;
    word       = '0;
    while (bit_cnt < total)
    begin
      wait_cnt = 0;
      step();
      while (out_valid !== 1'b1)
      begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT)
        begin
          $display("Timeout in %s: no output bit for %0d cycles", name, TIMEOUT);
          abort_run();
        end
        step();
      end
      word = {out_value, word[ACC_W-1:1]};
      bit_cnt++;
      if (bit_cnt % ACC_W == 0)
      begin
        got = acc_t'(word);
        got_q.push_back(int'(got));
        check($sformatf("%s word %0d", name, got_q.size() - 1),
              exp_q[got_q.size() - 1], 32'(got));
      end
    end
    extra = 0;
    repeat (QUIET)
    begin
      step();
      if (out_valid === 1'b1)
        extra++;
    end
    check($sformatf("%s out_valid cycles", name), exp_cycles, bit_cnt + extra);
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic test_reset();
    rst_n = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      step();
      check("reset held", 0, 32'(out_valid));
    end
    rst_n = 1'b1;
    for (int i = 0; i < 10; i++)
    begin
      step();
      check("after reset", 0, 32'(out_valid));
    end
  endtask

  task automatic test_small_job();
    load_all(0, 1'b0);
    run_job("8x8 job (0,0)", 0, 0, BITS_8X8);
  endtask

  // Two jobs back to back on the same load
  task automatic test_index_select();
    run_job("job (1,1)", 1, 1, BITS_8X8);
    run_job("job (1,0)", 1, 0, BITS_8X8);
  endtask

  task automatic test_signed_max();
    load_all(0, 1'b1);
    run_job("signed max job (0,1)", 0, 1, BITS_8X8);
  endtask

  task automatic test_large_job();
    load_all(1, 1'b0);
    run_job("16x16 job (0,1)", 0, 1, BITS_16X16);
  endtask

  // Burst while waiting for indexes replaces all stored data
  task automatic test_reload();
    load_all(0, 1'b0);
    run_job("reload job (0,1)", 0, 1, BITS_8X8);
  endtask

  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_valid2   = 1'b0;
    matrix      = '0;
    matrix_idx  = '0;
    matrix_size = '0;
    seed        = 32'hf111_855d;
    cur_n       = MAX_SIZE / 2;
    test_reset();
    test_small_job();
    test_index_select();
    test_signed_max();
    test_large_job();
    test_reload();
    $display("sim passed");
    $finish;
  end

endmodule

//--- src.f
+incdir+verification
verilog/cad_pkg.sv
verilog/cad_job_regs.sv
verilog/cad_load_ctrl.sv
verilog/cad_feature_mem.sv
verilog/cad_conv_sched.sv
verilog/cad_mac_pool.sv
verilog/cad_serializer.sv
verilog/cad_top.sv
verification/cad_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cad_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
BIN_NAME  ?= $(TOP)_sim
BIN       := $(OBJ_DIR)/$(BIN_NAME)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SRCS := $(wildcard verilog/*.sv) $(wildcard verification/*.sv) \
        $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(BIN_NAME)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
